//--- include/synth_params.svh
`ifndef SYNTH_PARAMS_SVH
`define SYNTH_PARAMS_SVH

// axi4-lite bus widths
`define SYNTH_ADDR_W 6
`define SYNTH_DATA_W 32

// note_clk cycles per waveform step, minus one
`define SYNTH_PERIOD_W 12

// register map, byte addresses
`define REG_SQ_CTRL    6'h00 // attack, decay, length of the square voice
`define REG_SQ_PERIOD  6'h04
`define REG_TRI_CTRL   6'h08 // length of the triangle voice
`define REG_TRI_PERIOD 6'h0C
`define REG_STATUS     6'h10 // read only, voice active flags

// volume steps of the square envelope
// attack and decay each take this many step times
`define ENV_STEPS 8

`endif

//--- verilog/synth_pkg.sv
`include "synth_params.svh"

package synth_pkg;

	// amplitude of a single voice, 0 to 15
	typedef logic [3:0] level_t;

	// two voices added, 0 to 30
	typedef logic [4:0] mix_t;

	typedef logic [`SYNTH_PERIOD_W-1:0] period_t; // pitch period in note_clk cycles

	// envelope rate select
	// 0 means instant, 1..3 pick longer step times
	typedef logic [1:0] rate_code_t;

	typedef logic [2:0] len_code_t; // note length select, table depends on the voice

	// waveform produced by one tone generator
	typedef enum logic
	{
		WAVE_SQUARE,
		WAVE_TRIANGLE
	} wave_kind_e;

endpackage

//--- verilog/synth_regs.sv
`timescale 1ns/1ns
`include "synth_params.svh"

module synth_regs
(
	input  logic note_clk,
	input  logic rst,
	input  logic [`SYNTH_ADDR_W-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [`SYNTH_DATA_W-1:0] wdata,
	input  logic wvalid,
	output logic wready,
	output logic bvalid,
	input  logic bready,
	output logic [1:0] bresp,
	input  logic [`SYNTH_ADDR_W-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic rvalid,
	input  logic rready,
	output logic [`SYNTH_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output synth_pkg::rate_code_t sq_attack,
	output synth_pkg::rate_code_t sq_decay,
	output synth_pkg::len_code_t sq_length,
	output synth_pkg::period_t sq_period,
	output logic sq_trigger,
	output synth_pkg::len_code_t tri_length,
	output synth_pkg::period_t tri_period,
	output logic tri_trigger,
	input  logic sq_active,
	input  logic tri_active
);

	logic wr_fire; // aw and w handshake in this cycle
	logic rd_fire;
	logic [`SYNTH_DATA_W-1:0] rd_word; // read data before the output register

	assign wr_fire = awready & awvalid & wvalid;
	assign rd_fire = arready & arvalid;
	assign bresp = 2'b00; // okay
	assign rresp = 2'b00;

	// write handshake
	always_ff @(posedge note_clk or posedge rst)
	begin
		if (rst)
		begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
		end
		else
		begin
			// address and data accepted together, never while a response waits
			awready <= awvalid & wvalid & ~awready & ~bvalid;
			wready <= awvalid & wvalid & ~awready & ~bvalid;
			if (wr_fire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0; // response taken
		end
	end

	// voice settings and note triggers
	always_ff @(posedge note_clk or posedge rst)
	begin
		if (rst)
		begin
			sq_attack <= '0;
			sq_decay <= '0;
			sq_length <= '0;
			sq_period <= '0;
			sq_trigger <= 1'b0;
			tri_length <= '0;
			tri_period <= '0;
			tri_trigger <= 1'b0;
		end
		else
		begin
			sq_trigger <= 1'b0; // one cycle pulse
			tri_trigger <= 1'b0;
			if (wr_fire)
			begin
				case (awaddr)
					`REG_SQ_CTRL:
					begin
						sq_attack <= wdata[1:0];
						sq_decay <= wdata[3:2];
						sq_length <= wdata[6:4];
						sq_trigger <= 1'b1; // starts a square note
					end
					`REG_SQ_PERIOD: sq_period <= wdata[`SYNTH_PERIOD_W-1:0];
					`REG_TRI_CTRL:
					begin
						tri_length <= wdata[2:0];
						tri_trigger <= 1'b1;
					end
					`REG_TRI_PERIOD: tri_period <= wdata[`SYNTH_PERIOD_W-1:0];
					default: ; // status is read only, rest unmapped
				endcase
			end
		end
	end

	// read decode
	always_comb
	begin
		case (araddr)
			`REG_SQ_CTRL: rd_word = `SYNTH_DATA_W'({sq_length, sq_decay, sq_attack});
			`REG_SQ_PERIOD: rd_word = `SYNTH_DATA_W'(sq_period);
			`REG_TRI_CTRL: rd_word = `SYNTH_DATA_W'(tri_length);
			`REG_TRI_PERIOD: rd_word = `SYNTH_DATA_W'(tri_period);
			`REG_STATUS: rd_word = `SYNTH_DATA_W'({tri_active, sq_active});
			default: rd_word = '0; // unmapped reads as zero
		endcase
	end

	// read handshake
	always_ff @(posedge note_clk or posedge rst)
	begin
		if (rst)
		begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			rdata <= '0;
		end
		else
		begin
			arready <= arvalid & ~arready & ~rvalid; // held off until rdata is taken
			if (rd_fire)
			begin
				rvalid <= 1'b1;
				rdata <= rd_word;
			end
			else if (rready)
				rvalid <= 1'b0;
		end
	end

endmodule

//--- verilog/tone_gen.sv
`timescale 1ns/1ns

module tone_gen
#(
	parameter synth_pkg::wave_kind_e wave_kind = synth_pkg::WAVE_SQUARE
)
(
	input  logic note_clk,
	input  logic rst,
	input  synth_pkg::period_t period,
	output synth_pkg::level_t wave
);

	import synth_pkg::*;

	period_t div_ctr; // cycles left in the current step
	logic step; // last cycle of a step

	assign step = (div_ctr == '0);

	// period divider, new period picked up only on reload
	always_ff @(posedge note_clk or posedge rst)
	begin
		if (rst)
			div_ctr <= '0;
		else if (step)
			div_ctr <= period;
		else
			div_ctr <= div_ctr - 1'b1;
	end

	generate
		if (wave_kind == WAVE_SQUARE)
		begin : g_square
			level_t sq_level; // either 0 or 15

			always_ff @(posedge note_clk or posedge rst)
			begin
				if (rst)
					sq_level <= '0;
				else if (step)
					sq_level <= ~sq_level; // flip between low and high
			end

			assign wave = sq_level;
		end
		else
		begin : g_triangle
			level_t tri_level;
			logic falling; // direction of the ramp

			always_ff @(posedge note_clk or posedge rst)
			begin
				if (rst)
				begin
					tri_level <= '0;
					falling <= 1'b0;
				end
				else if (step)
				begin
					if (!falling)
					begin
						if (tri_level == 4'hf)
						begin
							falling <= 1'b1; // top reached, turn around
							tri_level <= tri_level - 1'b1;
						end
						else
							tri_level <= tri_level + 1'b1;
					end
					else
					begin
						if (tri_level == 4'h0)
						begin
							falling <= 1'b0;
							tri_level <= tri_level + 1'b1;
						end
						else
							tri_level <= tri_level - 1'b1;
					end
				end
			end

			assign wave = tri_level;
		end
	endgenerate

endmodule

//--- verilog/envelope_control.sv
`timescale 1ns/1ns
`include "synth_params.svh"

module envelope_control
(
	input  logic note_clk,
	input  logic rst,
	input  logic trigger,
	input  synth_pkg::rate_code_t attack,
	input  synth_pkg::rate_code_t decay,
	input  synth_pkg::len_code_t length,
	input  synth_pkg::level_t square_in,
	output logic active,
	output synth_pkg::level_t square_out
);

	localparam logic [2:0] vol_max = 3'(`ENV_STEPS - 1); // loudest envelope step

	logic [5:0] atk_time; // ticks per attack step
	logic [5:0] dec_time;
	logic [10:0] atk_span; // whole attack, step time times steps
	logic [10:0] dec_span;
	logic [10:0] len_ticks; // note length, 8 to 1024
	logic [10:0] pos; // ticks since the trigger
	logic [10:0] remaining;
	logic [5:0] atk_ctr;
	logic [5:0] dec_ctr;
	logic [2:0] env_vol;

	// rate code to step time, shared by attack and decay
	function automatic logic [5:0] step_time(input logic [1:0] code);
		case (code)
			2'd0: step_time = 6'd0; // instant
			2'd1: step_time = 6'd4;
			2'd2: step_time = 6'd16;
			default: step_time = 6'd32;
		endcase
	endfunction

	assign atk_time = step_time(attack);
	assign dec_time = step_time(decay);
	assign atk_span = 11'(atk_time * `ENV_STEPS);
	assign dec_span = 11'(dec_time * `ENV_STEPS);
	assign len_ticks = 11'd8 << length; // doubles per code
	assign remaining = len_ticks - pos;

	always_ff @(posedge note_clk or posedge rst)
	begin
		if (rst)
		begin
			active <= 1'b0;
			pos <= '0;
			atk_ctr <= '0;
			dec_ctr <= '0;
			env_vol <= '0;
		end
		else if (trigger)
		begin
			// (re)start the note, also during a running one
			active <= 1'b1;
			pos <= '0;
			atk_ctr <= '0;
			dec_ctr <= '0;
			env_vol <= (atk_time == '0) ? vol_max : 3'd0; // no attack means full volume
		end
		else if (active)
		begin
			if (pos == len_ticks)
				active <= 1'b0; // last tick of the note
			else
				pos <= pos + 1'b1;

			if (pos < atk_span)
			begin
				// attack ramp, one step up every atk_time ticks
				if (atk_ctr == atk_time - 6'd1)
				begin
					atk_ctr <= '0;
					if (env_vol != vol_max)
						env_vol <= env_vol + 1'b1;
				end
				else
					atk_ctr <= atk_ctr + 1'b1;
			end
			else if (dec_time != '0 && remaining <= dec_span)
			begin
				// decay only in the tail of the note, after the attack
				if (dec_ctr == dec_time - 6'd1)
				begin
					dec_ctr <= '0;
					if (env_vol != 3'd0)
						env_vol <= env_vol - 1'b1;
				end
				else
					dec_ctr <= dec_ctr + 1'b1;
			end
		end
	end

	// volume scaling, high phase becomes 2 * env_vol + 1
	assign square_out = (square_in == '0) ? '0 : {env_vol, 1'b1};

endmodule

//--- verilog/length_control.sv
`timescale 1ns/1ns

module length_control
(
	input  logic note_clk,
	input  logic rst,
	input  logic trigger,
	input  synth_pkg::len_code_t length,
	input  synth_pkg::level_t wave_in,
	output logic active,
	output synth_pkg::level_t wave_out
);

	logic [8:0] len_ticks; // 2 to 256 ticks
	logic [8:0] pos; // ticks since the trigger

	assign len_ticks = 9'd2 << length;

	always_ff @(posedge note_clk or posedge rst)
	begin
		if (rst)
		begin
			active <= 1'b0;
			pos <= '0;
		end
		else if (trigger)
		begin
			active <= 1'b1; // retrigger restarts the count
			pos <= '0;
		end
		else if (active)
		begin
			if (pos == len_ticks)
				active <= 1'b0;
			else
				pos <= pos + 1'b1;
		end
	end

	assign wave_out = wave_in; // triangle has no envelope

endmodule

//--- verilog/channel_mixer.sv
`timescale 1ns/1ns

module channel_mixer
(
	input  logic note_clk,
	input  logic rst,
	input  synth_pkg::level_t sq_level,
	input  logic sq_active,
	input  synth_pkg::level_t tri_level,
	input  logic tri_active,
	output synth_pkg::mix_t sample
);

	import synth_pkg::*;

	level_t sq_gated; // zero while the voice is idle
	level_t tri_gated;

	assign sq_gated = sq_active ? sq_level : '0;
	assign tri_gated = tri_active ? tri_level : '0;

	// one extra bit keeps 15 + 15 from wrapping
	always_ff @(posedge note_clk or posedge rst)
	begin
		if (rst)
			sample <= '0;
		else
			sample <= mix_t'(sq_gated) + mix_t'(tri_gated);
	end

endmodule

//--- verilog/synth_top.sv
`timescale 1ns/1ns
`include "synth_params.svh"

module synth_top
(
	input  logic note_clk,
	input  logic rst,
	input  logic [`SYNTH_ADDR_W-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [`SYNTH_DATA_W-1:0] wdata,
	input  logic wvalid,
	output logic wready,
	output logic bvalid,
	input  logic bready,
	output logic [1:0] bresp,
	input  logic [`SYNTH_ADDR_W-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic rvalid,
	input  logic rready,
	output logic [`SYNTH_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output synth_pkg::mix_t sample
);

	import synth_pkg::*;

	rate_code_t sq_attack;
	rate_code_t sq_decay;
	len_code_t sq_length;
	period_t sq_period;
	logic sq_trigger;
	len_code_t tri_length;
	period_t tri_period;
	logic tri_trigger;
	logic sq_active; // note timers back to status
	logic tri_active;
	level_t sq_wave; // raw waveforms
	level_t tri_wave;
	level_t sq_level; // after envelope / length stage
	level_t tri_level;

	synth_regs u_regs
	(
		.note_clk(note_clk),
		.rst(rst),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wvalid(wvalid),
		.wready(wready),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rvalid(rvalid),
		.rready(rready),
		.rdata(rdata),
		.rresp(rresp),
		.sq_attack(sq_attack),
		.sq_decay(sq_decay),
		.sq_length(sq_length),
		.sq_period(sq_period),
		.sq_trigger(sq_trigger),
		.tri_length(tri_length),
		.tri_period(tri_period),
		.tri_trigger(tri_trigger),
		.sq_active(sq_active),
		.tri_active(tri_active)
	);

	// square voice
	tone_gen #(.wave_kind(WAVE_SQUARE)) u_sq_tone
	(
		.note_clk(note_clk),
		.rst(rst),
		.period(sq_period),
		.wave(sq_wave)
	);

	envelope_control u_sq_env
	(
		.note_clk(note_clk),
		.rst(rst),
		.trigger(sq_trigger),
		.attack(sq_attack),
		.decay(sq_decay),
		.length(sq_length),
		.square_in(sq_wave),
		.active(sq_active),
		.square_out(sq_level)
	);

	// triangle voice
	tone_gen #(.wave_kind(WAVE_TRIANGLE)) u_tri_tone
	(
		.note_clk(note_clk),
		.rst(rst),
		.period(tri_period),
		.wave(tri_wave)
	);

	length_control u_tri_len
	(
		.note_clk(note_clk),
		.rst(rst),
		.trigger(tri_trigger),
		.length(tri_length),
		.wave_in(tri_wave),
		.active(tri_active),
		.wave_out(tri_level)
	);

	channel_mixer u_mixer
	(
		.note_clk(note_clk),
		.rst(rst),
		.sq_level(sq_level),
		.sq_active(sq_active),
		.tri_level(tri_level),
		.tri_active(tri_active),
		.sample(sample)
	);

endmodule

//--- test/tb_synth.sv
`timescale 1ns/1ns
`include "synth_params.svh"

module tb_synth;

	import synth_pkg::*;

	localparam int clk_half = 4; // 8 ns clock
	localparam int drive_delay = 1; // inputs change 1 ns after the rising edge
	localparam int sq_longest = 1025; // square code 7 is 1024 ticks plus the last one
	localparam int tri_longest = 257; // triangle code 7
	localparam int watchdog_cycles = (sq_longest + tri_longest) * 2 + 1000;

	logic note_clk;
	logic rst;
	logic [`SYNTH_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [`SYNTH_DATA_W-1:0] wdata;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic bready;
	logic [1:0] bresp;
	logic [`SYNTH_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic rvalid;
	logic rready;
	logic [`SYNTH_DATA_W-1:0] rdata;
	logic [1:0] rresp;
	mix_t sample;

	integer seed; // $random state

	synth_top uut
	(
		.note_clk(note_clk),
		.rst(rst),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wvalid(wvalid),
		.wready(wready),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rvalid(rvalid),
		.rready(rready),
		.rdata(rdata),
		.rresp(rresp),
		.sample(sample)
	);

	initial
	begin
		note_clk = 1'b0;
		forever #clk_half note_clk = ~note_clk;
	end

	// watchdog bounds the whole run
	initial
	begin
		#(watchdog_cycles * 2 * clk_half);
		$display("timeout: the tests did not finish within %0d clock cycles", watchdog_cycles);
		$display("Test FAILED");
		$fatal(1, "watchdog expired");
	end

	task automatic stop_failed();
		$display("Test FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		stop_failed();
	endtask

	task automatic next_cycle();
		@(posedge note_clk);
		#drive_delay; // outputs have settled here
	endtask

	task automatic check_data(input logic [`SYNTH_DATA_W-1:0] got,
		input logic [`SYNTH_DATA_W-1:0] exp, input string what);
		if (got !== exp)
		begin
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
			stop_failed();
		end
	endtask

	task automatic check_status(input logic [1:0] got, input logic [1:0] exp, input string what);
		if (got !== exp)
		begin
			$display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
			stop_failed();
		end
	endtask

	task automatic check_sample(input mix_t got, input mix_t exp, input string what);
		if (got !== exp)
		begin
			$display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			stop_failed();
		end
	endtask

	// one aw+w transfer that returns while the trigger pulse is high
	task automatic axi_write(input logic [`SYNTH_ADDR_W-1:0] addr,
		input logic [`SYNTH_DATA_W-1:0] data);
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = 1'b1;
		next_cycle();
		while (!(awready && wready))
			next_cycle(); // slave holds off while a response waits
		next_cycle(); // handshake edge
		awvalid = 1'b0;
		wvalid = 1'b0;
		while (!bvalid)
			next_cycle();
		check_data({30'b0, bresp}, 32'h0, "bresp");
	endtask

	task automatic axi_read(input logic [`SYNTH_ADDR_W-1:0] addr,
		output logic [`SYNTH_DATA_W-1:0] data);
		araddr = addr;
		arvalid = 1'b1;
		rready = 1'b1;
		next_cycle();
		while (!arready)
			next_cycle();
		next_cycle(); // address taken here
		arvalid = 1'b0;
		while (!rvalid)
			next_cycle();
		data = rdata;
		check_data({30'b0, rresp}, 32'h0, "rresp");
	endtask

	// poll status until both voices are quiet
	task automatic wait_idle();
		logic [`SYNTH_DATA_W-1:0] rd;
		axi_read(`REG_STATUS, rd);
		while (rd[1:0] != 2'b00)
			axi_read(`REG_STATUS, rd);
		repeat (2) next_cycle(); // mixer register drains
	endtask

	task automatic test_silence(input int cycles);
		for (int i = 0; i < cycles; i++)
		begin
			next_cycle();
			check_sample(sample, 5'd0, "idle sample");
		end
	endtask

	task automatic test_register_access();
		logic [`SYNTH_DATA_W-1:0] rnd;
		logic [`SYNTH_DATA_W-1:0] sq_per;
		logic [`SYNTH_DATA_W-1:0] tri_per;
		logic [`SYNTH_DATA_W-1:0] rd;
		rnd = $random(seed);
		sq_per = {20'b0, rnd[11:0]};
		rnd = $random(seed);
		tri_per = {20'b0, rnd[11:0]};
		axi_write(`REG_STATUS, 32'h3); // status is read only
		axi_read(`REG_STATUS, rd);
		check_data(rd, 32'h0, "status after a write to it");
		axi_read(6'h14, rd);
		check_data(rd, 32'h0, "unmapped read");
		axi_write(`REG_SQ_PERIOD, sq_per);
		axi_write(`REG_TRI_PERIOD, tri_per);
		axi_read(`REG_SQ_PERIOD, rd);
		check_data(rd, sq_per, "square period readback");
		axi_read(`REG_TRI_PERIOD, rd);
		check_data(rd, tri_per, "triangle period readback");
		axi_write(`REG_SQ_CTRL, 32'h35); // attack 1, decay 1, length code 3
		axi_write(`REG_TRI_CTRL, 32'h5);
		axi_read(`REG_SQ_CTRL, rd);
		check_data(rd, 32'h35, "square control readback");
		axi_read(`REG_TRI_CTRL, rd);
		check_data(rd, 32'h5, "triangle control readback");
		wait_idle();
	endtask

	task automatic test_note_length();
		logic exp_on;
		logic [`SYNTH_DATA_W-1:0] rd;
		axi_write(`REG_SQ_CTRL, 32'h0); // 8 ticks give 9 active cycles
		check_status({uut.tri_active, uut.sq_active}, 2'b00, "status on the trigger cycle");
		for (int i = 1; i <= 14; i++)
		begin
			next_cycle();
			exp_on = (i <= 9);
			check_status({uut.tri_active, uut.sq_active}, {1'b0, exp_on}, "square active");
		end
		axi_write(`REG_TRI_CTRL, 32'h1); // 4 ticks give 5 active cycles
		check_status({uut.tri_active, uut.sq_active}, 2'b00, "status on the trigger cycle");
		for (int i = 1; i <= 10; i++)
		begin
			next_cycle();
			exp_on = (i <= 5);
			check_status({uut.tri_active, uut.sq_active}, {exp_on, 1'b0}, "triangle active");
		end
		axi_write(`REG_TRI_CTRL, 32'h3);
		axi_read(`REG_STATUS, rd); // bit 1 seen through the bus
		check_data(rd, 32'h2, "status during a triangle note");
		wait_idle();
	endtask

	task automatic test_square_full();
		logic [`SYNTH_DATA_W-1:0] rnd;
		mix_t s;
		int highs;
		int lows;
		highs = 0;
		lows = 0;
		rnd = $random(seed);
		axi_write(`REG_SQ_PERIOD, {29'b0, rnd[2:0]}); // short steps give many flips
		axi_write(`REG_SQ_CTRL, 32'h30); // no attack, no decay, 64 ticks
		next_cycle(); // active rises and the sample follows a cycle later
		for (int i = 0; i < 65; i++)
		begin
			next_cycle();
			s = sample;
			check_sample(s, (s == 5'd15) ? 5'd15 : 5'd0, "full volume square");
			if (s == 5'd15)
				highs++;
			else
				lows++;
		end
		if (highs == 0 || lows == 0)
			abort_run("square note at full volume did not show both 0 and 15");
	endtask

	task automatic test_attack_ramp();
		logic [`SYNTH_DATA_W-1:0] rnd;
		mix_t s;
		mix_t prev_hi; // last nonzero sample
		logic reached;
		prev_hi = 5'd0;
		reached = 1'b0;
		rnd = $random(seed);
		axi_write(`REG_SQ_PERIOD, {28'b0, rnd[3:0]});
		axi_write(`REG_SQ_CTRL, 32'h71); // attack 1, decay 0, 1024 ticks
		next_cycle();
		for (int i = 0; i < sq_longest; i++)
		begin
			next_cycle();
			s = sample;
			if (s != 5'd0)
			begin
				check_sample(s, s | 5'd1, "high phase level");
				if (s < prev_hi)
					check_sample(s, prev_hi, "attack ramp level");
				prev_hi = s;
				if (s == 5'd15)
					reached = 1'b1;
			end
		end
		if (!reached)
			abort_run("attack ramp never reached full volume during the note");
	endtask

	task automatic test_triangle();
		logic [`SYNTH_DATA_W-1:0] rnd;
		mix_t s;
		mix_t prev;
		int bottoms;
		int tops;
		prev = 5'd0;
		bottoms = 0;
		tops = 0;
		rnd = $random(seed);
		axi_write(`REG_TRI_PERIOD, {29'b0, rnd[2:0]}); // a full sweep fits the note
		axi_write(`REG_TRI_CTRL, 32'h7); // 256 ticks
		next_cycle();
		for (int i = 0; i < tri_longest; i++)
		begin
			next_cycle();
			s = sample;
			check_sample(s, (s > 5'd15) ? 5'd15 : s, "triangle range");
			if (i > 0 && s != prev)
				check_sample(s, (s > prev) ? prev + 5'd1 : prev - 5'd1, "triangle step");
			prev = s;
			if (s == 5'd0)
				bottoms++;
			if (s == 5'd15)
				tops++;
		end
		if (bottoms == 0 || tops == 0)
			abort_run("triangle note did not reach both 0 and 15");
	endtask

	initial
	begin
		seed = 32'h121f73f6;
		rst = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		for (int i = 0; i < 10; i++)
		begin
			@(posedge note_clk);
			#drive_delay;
			check_sample(sample, 5'd0, "sample in reset");
		end
		rst = 1'b0;
		check_data({27'b0, awready, wready, bvalid, arready, rvalid}, 32'h0,
			"handshake outputs after reset");
		test_silence(20);
		test_note_length();
		test_silence(20); // tone generators run while the voices are gated off
		test_square_full();
		wait_idle();
		test_attack_ramp();
		wait_idle();
		test_triangle();
		wait_idle();
		// long random periods stay loaded in the dividers for a full step
		test_register_access();
		test_silence(20);
		$display("Test OK");
		$finish;
	end

endmodule

//--- build.f
+incdir+include
verilog/synth_pkg.sv
verilog/synth_regs.sv
verilog/tone_gen.sv
verilog/envelope_control.sv
verilog/length_control.sv
verilog/channel_mixer.sv
verilog/synth_top.sv
test/tb_synth.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns -f build.f \
	--top-module tb_synth -Mdir obj_dir -o tb_synth

obj_dir/tb_synth 2>&1 | tee sim.log

if grep -q "Test FAILED" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if ! grep -q "Test OK" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"
